// File: source/vertex_pkg.sv
// Shared widths, sizes, opcodes and payload structs
// for the vertex update router
package vertex_pkg;

	// ------------------------------
	// Widths and default sizes
	// ------------------------------

	// Vertex value and id widths
	parameter int value_w = 32;
	parameter int id_w    = 8;

	// Default geometry, both powers of two
	parameter int lanes_default = 8;
	parameter int depth_default = 4;

	// ------------------------------
	// Opcodes
	// ------------------------------

	typedef enum logic [1:0] {
		op_write = 2'd0,
		op_add   = 2'd1,
		op_read  = 2'd2
	} vertex_op_e;

	// ------------------------------
	// Payload structs
	// ------------------------------

	// Host command, 42 bits
	typedef struct packed {
		vertex_op_e         op;
		logic [id_w-1:0]    id;
		logic [value_w-1:0] value;
	} host_cmd_t;

	// Lane command, 43 bits
	// Slot is id wide, upper bits stay zero for small depths
	typedef struct packed {
		logic               valid;
		vertex_op_e         op;
		logic [id_w-1:0]    slot;
		logic [value_w-1:0] value;
	} lane_cmd_t;

	// Lane read result, 33 bits
	typedef struct packed {
		logic               valid;
		logic [value_w-1:0] value;
	} lane_rsp_t;

	// Host read response, 40 bits
	typedef struct packed {
		logic [id_w-1:0]    id;
		logic [value_w-1:0] value;
	} host_rsp_t;

endpackage

// File: source/command_ingress.sv
// Command ingress: four-phase receiver, vertex id decode
// and one-cycle lane command issue
module command_ingress #(
	parameter int LANES = vertex_pkg::lanes_default,
	parameter int DEPTH = vertex_pkg::depth_default
) (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          cmd_req,
	input  vertex_pkg::host_cmd_t         cmd,
	output logic                          cmd_ack,
	output vertex_pkg::lane_cmd_t         lane_cmd,
	output logic [$clog2(LANES)-1:0]      lane_sel,
	output logic [vertex_pkg::id_w-1:0]   read_id,
	input  logic                          done
);

	import vertex_pkg::*;

	localparam int LANE_W = $clog2(LANES);

	// Read in flight, blocks further acks
	logic            pending;
	logic            accept;
	logic [id_w-1:0] slot_num;

	// ------------------------------
	// Handshake and decode
	// ------------------------------

	// New request seen, no ack up yet and no read outstanding
	assign accept = cmd_req && !cmd_ack && !pending;

	// Slot = (id / LANES) mod DEPTH
	assign slot_num = (cmd.id >> LANE_W) & id_w'(DEPTH - 1);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_ack  <= 1'b0;
			pending  <= 1'b0;
			lane_cmd <= '0;
			lane_sel <= '0;
			read_id  <= '0;
		end else begin
			// Lane command lives for one cycle only
			lane_cmd <= '0;
			if (accept) begin
				cmd_ack        <= 1'b1;
				lane_cmd.valid <= 1'b1;
				lane_cmd.op    <= cmd.op;
				lane_cmd.slot  <= slot_num;
				lane_cmd.value <= cmd.value;
				// Lane = id mod LANES
				lane_sel       <= cmd.id[LANE_W-1:0];
				if (cmd.op == op_read) begin
					pending <= 1'b1;
					read_id <= cmd.id;
				end
			end else begin
				// Host dropped req, finish the four phases
				if (cmd_ack && !cmd_req) begin
					cmd_ack <= 1'b0;
				end
				// Response handshake complete
				if (done) begin
					pending <= 1'b0;
				end
			end
		end
	end

endmodule

// File: source/demux_bus.sv
// Three-stage registered demultiplexer, one payload to one of LANES
// outputs, unselected outputs held at zero
module demux_bus #(
	parameter int  LANES     = vertex_pkg::lanes_default,
	parameter type payload_t = logic [31:0]
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled,
	input  logic [$clog2(LANES)-1:0] sel,
	input  payload_t                 data,
	output payload_t                 data_out [LANES]
);

	localparam int SEL_W = $clog2(LANES);

	// Stage 1 input capture
	logic             stage_en;
	logic [SEL_W-1:0] stage_sel;
	payload_t         stage_data;
	// Stage 2 gated copy
	logic [SEL_W-1:0] held_sel;
	payload_t         held_data;
	// Decoded fan-out before stage 3
	payload_t         decoded [LANES];

	// ------------------------------
	// Stage 1 and 2
	// ------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stage_en   <= 1'b0;
			stage_sel  <= '0;
			stage_data <= '0;
		end else begin
			stage_en   <= enabled;
			stage_sel  <= sel;
			stage_data <= data;
		end
	end

	// Only enabled beats pass, anything else becomes zero
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			held_sel  <= '0;
			held_data <= '0;
		end else if (stage_en) begin
			held_sel  <= stage_sel;
			held_data <= stage_data;
		end else begin
			held_sel  <= '0;
			held_data <= '0;
		end
	end

	// ------------------------------
	// Decode and stage 3
	// ------------------------------

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			decoded[i] = (held_sel == SEL_W'(i)) ? held_data : '0;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < LANES; i++) begin
				data_out[i] <= '0;
			end
		end else begin
			data_out <= decoded;
		end
	end

endmodule

// File: source/lane_accumulator.sv
// Per-lane vertex value store with write, add and read
module lane_accumulator #(
	parameter int DEPTH = vertex_pkg::depth_default
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  vertex_pkg::lane_cmd_t cmd,
	output vertex_pkg::lane_rsp_t rsp
);

	import vertex_pkg::*;

	localparam int SLOT_W = $clog2(DEPTH);

	// Vertex values of this lane
	logic [value_w-1:0] values [DEPTH];
	// Addressed slot, upper slot bits ignored
	logic [SLOT_W-1:0]  slot;

	assign slot = cmd.slot[SLOT_W-1:0];

	// ------------------------------
	// Update and read
	// ------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < DEPTH; i++) begin
				values[i] <= '0;
			end
			rsp <= '0;
		end else begin
			// Idle lane drives zeros into the mux bus
			rsp <= '0;
			if (cmd.valid) begin
				case (cmd.op)
					op_write: values[slot] <= cmd.value;
					// Wraps at 32 bits
					op_add:   values[slot] <= values[slot] + cmd.value;
					op_read: begin
						rsp.valid <= 1'b1;
						rsp.value <= values[slot];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: source/mux_bus.sv
// Two-stage registered multiplexer, ORs the lane results into
// one output, expects at most one valid lane and zeros elsewhere
module mux_bus #(
	parameter int  LANES     = vertex_pkg::lanes_default,
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rstn,
	input  payload_t data_in [LANES],
	output payload_t data_out
);

	// Stage 1 copy of every lane
	payload_t stage [LANES];
	// OR of all lanes
	payload_t merged;

	// ------------------------------
	// Stage 1
	// ------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < LANES; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage <= data_in;
		end
	end

	// Idle lanes are zero so a plain OR selects the active one
	always_comb begin
		merged = '0;
		for (int i = 0; i < LANES; i++) begin
			merged = payload_t'(merged | stage[i]);
		end
	end

	// ------------------------------
	// Stage 2
	// ------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_out <= '0;
		end else begin
			data_out <= merged;
		end
	end

endmodule

// File: source/response_egress.sv
// Response egress: captures a read result and runs the
// sender side of the four-phase response link
module response_egress (
	input  logic                        clock,
	input  logic                        rstn,
	input  vertex_pkg::lane_rsp_t       result,
	input  logic [vertex_pkg::id_w-1:0] read_id,
	output vertex_pkg::host_rsp_t       rsp,
	output logic                        rsp_req,
	input  logic                        rsp_ack,
	output logic                        done
);

	import vertex_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_done
	} egress_state_e;

	egress_state_e state;

	// ------------------------------
	// Sender FSM
	// ------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= st_idle;
			rsp     <= '0;
			rsp_req <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				// Wait for the lane result, id comes from ingress
				st_idle: begin
					if (result.valid) begin
						rsp.id    <= read_id;
						rsp.value <= result.value;
						rsp_req   <= 1'b1;
						state     <= st_req;
					end
				end
				// Response held stable until the host acks
				st_req: begin
					if (rsp_ack) begin
						rsp_req <= 1'b0;
						state   <= st_done;
					end
				end
				// Done one cycle after req falls
				st_done: begin
					done  <= 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: source/vertex_route_top.sv
// Vertex update router top: ingress, demux bus, lane accumulators,
// mux bus and response egress
module vertex_route_top #(
	parameter int LANES = vertex_pkg::lanes_default,
	parameter int DEPTH = vertex_pkg::depth_default
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  cmd_req,
	input  vertex_pkg::host_cmd_t cmd,
	output logic                  cmd_ack,
	output vertex_pkg::host_rsp_t rsp,
	output logic                  rsp_req,
	input  logic                  rsp_ack
);

	import vertex_pkg::*;

	// Ingress to demux
	lane_cmd_t                lane_cmd;
	logic [$clog2(LANES)-1:0] lane_sel;
	// Demux to lanes, lanes to mux
	lane_cmd_t                lane_cmds [LANES];
	lane_rsp_t                lane_rsps [LANES];
	// Mux to egress
	lane_rsp_t                result;
	// Ingress and egress side band
	logic [id_w-1:0]          read_id;
	logic                     done;

	// ------------------------------
	// Command path
	// ------------------------------

	command_ingress #(
		.LANES(LANES),
		.DEPTH(DEPTH)
	) i_command_ingress (
		.clock   (clock),
		.rstn    (rstn),
		.cmd_req (cmd_req),
		.cmd     (cmd),
		.cmd_ack (cmd_ack),
		.lane_cmd(lane_cmd),
		.lane_sel(lane_sel),
		.read_id (read_id),
		.done    (done)
	);

	// Command valid doubles as the demux enable
	demux_bus #(
		.LANES    (LANES),
		.payload_t(lane_cmd_t)
	) i_demux_bus (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (lane_cmd.valid),
		.sel     (lane_sel),
		.data    (lane_cmd),
		.data_out(lane_cmds)
	);

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		lane_accumulator #(
			.DEPTH(DEPTH)
		) i_lane_accumulator (
			.clock(clock),
			.rstn (rstn),
			.cmd  (lane_cmds[g]),
			.rsp  (lane_rsps[g])
		);
	end

	// ------------------------------
	// Response path
	// ------------------------------

	mux_bus #(
		.LANES    (LANES),
		.payload_t(lane_rsp_t)
	) i_mux_bus (
		.clock   (clock),
		.rstn    (rstn),
		.data_in (lane_rsps),
		.data_out(result)
	);

	response_egress i_response_egress (
		.clock  (clock),
		.rstn   (rstn),
		.result (result),
		.read_id(read_id),
		.rsp    (rsp),
		.rsp_req(rsp_req),
		.rsp_ack(rsp_ack),
		.done   (done)
	);

endmodule

// File: verif/vertex_route_tb.sv
// Testbench for the vertex update router: stimulus table, host handshake
// drivers, reference model and compare tasks
module vertex_route_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import vertex_pkg::*;

	localparam int num_entries = 48;
	// Generous per-entry budget, covers slow acks and the read latency
	localparam int max_cycles  = num_entries * 40;
	localparam int lanes       = lanes_default;
	localparam int depth       = depth_default;
	localparam int read_lat    = 7;
	localparam int slow_cycles = 6;

	typedef struct {
		vertex_op_e         op;
		logic [id_w-1:0]    id;
		logic [value_w-1:0] value;
		bit                 slow_ack;
	} stim_entry_t;

	logic      clock = 1'b0;
	logic      rstn;
	logic      cmd_req;
	host_cmd_t cmd;
	logic      cmd_ack;
	host_rsp_t rsp;
	logic      rsp_req;
	logic      rsp_ack;

	stim_entry_t        stim [num_entries];
	int                 fill = 0;
	// Expected vertex values, indexed slot * lanes + lane
	logic [value_w-1:0] model [lanes * depth];
	int                 cycles = 0;
	int                 ack_cycle = 0;
	// Next command already on the link during a slow response
	bit                 preloaded = 1'b0;

	vertex_route_top i_vertex_route_top (
		.clock  (clock),
		.rstn   (rstn),
		.cmd_req(cmd_req),
		.cmd    (cmd),
		.cmd_ack(cmd_ack),
		.rsp    (rsp),
		.rsp_req(rsp_req),
		.rsp_ack(rsp_ack)
	);

	always #5 clock = ~clock;

	// ------------------------------
	// Run limit and error handling
	// ------------------------------

	task automatic stop_on_error();
		$display("TEST FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			stop_on_error();
		end
	end

	task automatic check_rsp(input host_rsp_t expected, input host_rsp_t actual);
		if (actual !== expected) begin
			$display("FAILED rsp expected id %h value %h, got id %h value %h",
				expected.id, expected.value, actual.id, actual.value);
			stop_on_error();
		end
	endtask

	// Handshake outputs against their expected levels
	task automatic check_ack_idle(input logic exp_cmd_ack, input logic exp_rsp_req);
		if (cmd_ack !== exp_cmd_ack) begin
			$display("FAILED cmd_ack expected %h got %h", exp_cmd_ack, cmd_ack);
			stop_on_error();
		end
		if (rsp_req !== exp_rsp_req) begin
			$display("FAILED rsp_req expected %h got %h", exp_rsp_req, rsp_req);
			stop_on_error();
		end
	endtask

	task automatic check_latency(input int expected, input int actual);
		if (actual != expected) begin
			$display("FAILED rsp_req latency expected %h got %h", expected, actual);
			stop_on_error();
		end
	endtask

	// ------------------------------
	// Stimulus table and model
	// ------------------------------

	task automatic add_entry(input vertex_op_e op, input int id,
		input logic [value_w-1:0] value, input bit slow);
		stim[fill].op       = op;
		stim[fill].id       = id_w'(id);
		stim[fill].value    = value;
		stim[fill].slow_ack = slow;
		fill++;
	endtask

	task automatic build_table();
		// Untouched vertices read as zero
		add_entry(op_read, 0, 0, 0);
		add_entry(op_read, 13, 0, 0);
		add_entry(op_read, 31, 0, 0);
		add_entry(op_write, 5, $urandom, 0);
		add_entry(op_read, 5, 0, 0);
		// Wrap past 32 bits on the first add
		add_entry(op_write, 9, 32'hffff_fff0, 0);
		add_entry(op_add, 9, 32'h20, 0);
		add_entry(op_add, 9, $urandom, 0);
		add_entry(op_add, 9, $urandom, 0);
		add_entry(op_read, 9, 0, 0);
		// Slot 2 in every lane, then the other slots of lane 3
		for (int i = 16; i < 24; i++) begin
			add_entry(op_write, i, $urandom, 0);
		end
		add_entry(op_write, 3, $urandom, 0);
		add_entry(op_write, 11, $urandom, 0);
		add_entry(op_write, 27, $urandom, 0);
		for (int i = 16; i < 24; i++) begin
			add_entry(op_read, i, 0, 0);
		end
		add_entry(op_read, 3, 0, 0);
		add_entry(op_read, 11, 0, 0);
		add_entry(op_read, 27, 0, 0);
		// Id 40 lands on lane 0 slot 1, same place as id 8
		add_entry(op_write, 40, $urandom, 0);
		add_entry(op_read, 40, 0, 1);
		add_entry(op_read, 19, 0, 1);
		// Back-to-back adds then a read of the sum
		add_entry(op_write, 30, 0, 0);
		for (int i = 0; i < 10; i++) begin
			add_entry(op_add, 30, $urandom, 0);
		end
		add_entry(op_read, 30, 0, 0);
		add_entry(op_read, 8, 0, 1);
	endtask

	// lane = id mod lanes, slot = (id / lanes) mod depth
	function automatic int model_index(input logic [id_w-1:0] id);
		int lane;
		int slot;
		lane = int'(id) % lanes;
		slot = (int'(id) / lanes) % depth;
		return slot * lanes + lane;
	endfunction

	// ------------------------------
	// Host side handshakes
	// ------------------------------

	task automatic send_command(input stim_entry_t e);
		if (!preloaded) begin
			check_ack_idle(1'b0, 1'b0);
			cmd     = '{op: e.op, id: e.id, value: e.value};
			cmd_req = 1'b1;
		end
		preloaded = 1'b0;
		while (!cmd_ack) @(negedge clock);
		ack_cycle = cycles;
		cmd_req   = 1'b0;
		while (cmd_ack) @(negedge clock);
	endtask

	task automatic collect_response(input host_rsp_t expected, input bit slow, input int next);
		while (!rsp_req) @(negedge clock);
		check_latency(read_lat, cycles - ack_cycle);
		check_rsp(expected, rsp);
		if (slow) begin
			// Offer the next command early, it must wait for the response
			if (next < num_entries) begin
				cmd       = '{op: stim[next].op, id: stim[next].id, value: stim[next].value};
				cmd_req   = 1'b1;
				preloaded = 1'b1;
			end
			repeat (slow_cycles) begin
				@(negedge clock);
				check_ack_idle(1'b0, 1'b1);
				check_rsp(expected, rsp);
			end
		end
		rsp_ack = 1'b1;
		@(negedge clock);
		while (rsp_req) @(negedge clock);
		rsp_ack = 1'b0;
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial begin : run_tests
		host_rsp_t expected;
		int        idx;
		rstn    = 1'b0;
		cmd_req = 1'b0;
		cmd     = '0;
		rsp_ack = 1'b0;
		void'($urandom(12286));
		foreach (model[k]) begin
			model[k] = '0;
		end
		build_table();
		if (fill != num_entries) begin
			$display("Stimulus table holds %0d entries instead of %0d", fill, num_entries);
			stop_on_error();
		end
		repeat (8) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_ack_idle(1'b0, 1'b0);
		for (int i = 0; i < num_entries; i++) begin
			idx = model_index(stim[i].id);
			send_command(stim[i]);
			case (stim[i].op)
				op_write: model[idx] = stim[i].value;
				op_add:   model[idx] = model[idx] + stim[i].value;
				default: begin
					expected.id    = stim[i].id;
					expected.value = model[idx];
					collect_response(expected, stim[i].slow_ack, i + 1);
				end
			endcase
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: build.f
source/vertex_pkg.sv
source/command_ingress.sv
source/demux_bus.sv
source/lane_accumulator.sv
source/mux_bus.sv
source/response_egress.sv
source/vertex_route_top.sv
verif/vertex_route_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and scan the log for a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f build.f --top-module vertex_route_tb -o vertex_route_sim

./obj_dir/vertex_route_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failure"
